// ==== common/spi_pkg.sv ====
package spi_pkg;

    // --------------------------------------------------
    // Sizes and defaults
    // --------------------------------------------------
    localparam int DATA_W          = 8;   // Bits per transfer
    localparam int CLK_DIV_DEFAULT = 4;   // pllClk_i cycles per SCLK half period
    localparam int SYNC_STAGES     = 2;   // Slave input synchronizer depth

    // --------------------------------------------------
    // State encodings
    // --------------------------------------------------

    // Master transfer sequence
    typedef enum logic [1:0] {
        M_IDLE  = 2'd0,   // Waiting for req
        M_SETUP = 2'd1,   // Select low, first edge pending
        M_SHIFT = 2'd2,   // Clocking the bits
        M_DONE  = 2'd3    // Ack high until req drops
    } master_state_e;

    // Slave only knows whether select is active
    typedef enum logic {
        S_IDLE   = 1'b0,  // Select high
        S_ACTIVE = 1'b1   // Shifting
    } slave_state_e;

endpackage

// ==== common/spi_link_if.sv ====
// The four SPI wires between master and slave
interface spi_link_if;

    logic sclk;   // Serial clock, idles low (mode 0)
    logic mosi;   // Master out, slave in
    logic miso;   // Master in, slave out
    logic ss_n;   // Slave select, active low

    // Master drives clock, data out and select
    modport mst (
        output sclk,
        output mosi,
        output ss_n,
        input  miso
    );

    // Slave only drives its data line back
    modport slv (
        input  sclk,
        input  mosi,
        input  ss_n,
        output miso
    );

endinterface

// ==== spi_master/spi_master.sv ====
module spi_master #(
    parameter int CLK_DIV = spi_pkg::CLK_DIV_DEFAULT
) (
    input  logic                       pllClk_i,
    input  logic                       rst_n_i,
    input  logic                       send_req_i,   // Four-phase request
    output logic                       send_ack_o,   // Four-phase acknowledge
    input  logic [spi_pkg::DATA_W-1:0] tx_byte_i,    // Byte out on MOSI
    output logic [spi_pkg::DATA_W-1:0] rx_byte_o,    // Byte collected from MISO
    spi_link_if.mst                    link
);

    localparam int DW        = spi_pkg::DATA_W;
    localparam int CNT_W     = $clog2(CLK_DIV);
    localparam int HALF_LAST = 2 * DW;               // Half periods incl. trailing hold
    localparam int HALF_W    = $clog2(HALF_LAST + 1);

    spi_pkg::master_state_e state;

    logic [CNT_W-1:0]  div_cnt;     // Half period divider
    logic [HALF_W-1:0] half_cnt;    // Half periods done since first rise
    logic              tick;        // End of a half period
    logic              edge_en;     // SCLK toggles this cycle
    logic              rise_en;
    logic              fall_en;
    logic              sclk_q;
    logic              ss_n_q;
    logic [DW-1:0]     tx_sr;       // MSB goes out first
    logic [DW-1:0]     rx_sr;

    // --------------------------------------------------
    // Divider runs only while select is low
    // --------------------------------------------------
    assign tick = (div_cnt == CNT_W'(CLK_DIV - 1));

    always_ff @(posedge pllClk_i) begin
        if (!rst_n_i) begin
            div_cnt <= '0;
        end else if (state == spi_pkg::M_SETUP || state == spi_pkg::M_SHIFT) begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
        end else begin
            div_cnt <= '0;   // Restart aligned to select fall
        end
    end

    // First edge comes from SETUP and the last tick of SHIFT is the trailing hold
    assign edge_en = tick && ((state == spi_pkg::M_SETUP) ||
                              (state == spi_pkg::M_SHIFT && half_cnt != HALF_W'(HALF_LAST)));
    assign rise_en = edge_en && !sclk_q;
    assign fall_en = edge_en && sclk_q;

    // --------------------------------------------------
    // Transfer FSM
    // --------------------------------------------------
    always_ff @(posedge pllClk_i) begin
        if (!rst_n_i) begin
            state      <= spi_pkg::M_IDLE;
            half_cnt   <= '0;
            sclk_q     <= 1'b0;
            ss_n_q     <= 1'b1;
            send_ack_o <= 1'b0;
            rx_byte_o  <= '0;
        end else begin
            case (state)
                spi_pkg::M_IDLE: begin
                    if (send_req_i) begin
                        ss_n_q <= 1'b0;              // Select falls now
                        state  <= spi_pkg::M_SETUP;
                    end
                end
                spi_pkg::M_SETUP: begin
                    if (tick) begin
                        sclk_q   <= 1'b1;            // Rise for bit 7
                        half_cnt <= HALF_W'(1);
                        state    <= spi_pkg::M_SHIFT;
                    end
                end
                spi_pkg::M_SHIFT: begin
                    if (edge_en) begin
                        sclk_q   <= ~sclk_q;
                        half_cnt <= half_cnt + 1'b1;
                    end else if (tick) begin
                        // SCLK low for N cycles then close the frame
                        ss_n_q     <= 1'b1;
                        send_ack_o <= 1'b1;
                        rx_byte_o  <= rx_sr;
                        state      <= spi_pkg::M_DONE;
                    end
                end
                spi_pkg::M_DONE: begin
                    if (!send_req_i) begin
                        send_ack_o <= 1'b0;          // One cycle after req drops
                        state      <= spi_pkg::M_IDLE;
                    end
                end
                default: state <= spi_pkg::M_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Shift registers
    // --------------------------------------------------
    always_ff @(posedge pllClk_i) begin
        if (state == spi_pkg::M_IDLE && send_req_i) begin
            tx_sr <= tx_byte_i;                      // Capture at start
        end else if (fall_en) begin
            tx_sr <= {tx_sr[DW-2:0], 1'b0};          // Next bit on falling edge
        end
        if (rise_en) begin
            rx_sr <= {rx_sr[DW-2:0], link.miso};     // Mode 0 sample on rise
        end
    end

    assign link.sclk = sclk_q;
    assign link.ss_n = ss_n_q;
    assign link.mosi = tx_sr[DW-1];

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // Slave needs SYNC_STAGES+1 cycles to see an edge and answer
    a_clk_div_min: assert property (@(posedge pllClk_i)
        CLK_DIV >= spi_pkg::SYNC_STAGES + 2);

    a_ack_needs_req: assert property (@(posedge pllClk_i) disable iff (!rst_n_i)
        $rose(send_ack_o) |-> $past(send_req_i));

    // Select low throughout SHIFT and whenever SCLK is high
    a_ss_low_in_shift: assert property (@(posedge pllClk_i) disable iff (!rst_n_i)
        (state == spi_pkg::M_SHIFT || sclk_q) |-> !link.ss_n);

endmodule

// ==== spi_slave/spi_slave.sv ====
module spi_slave (
    input  logic                       pllClk_i,
    input  logic                       rst_n_i,
    input  logic [spi_pkg::DATA_W-1:0] tx_byte_i,   // Byte returned on MISO
    output logic [spi_pkg::DATA_W-1:0] rx_byte_o,   // Byte collected from MOSI
    spi_link_if.slv                    link
);

    localparam int DW    = spi_pkg::DATA_W;
    localparam int SYNC  = spi_pkg::SYNC_STAGES;
    localparam int CNT_W = $clog2(DW + 1);

    spi_pkg::slave_state_e state;

    logic [SYNC-1:0]  sclk_sync;   // SCLK treated as foreign
    logic [SYNC-1:0]  ss_sync;
    logic             sclk_s;
    logic             ss_s;
    logic             sclk_d;      // Previous synced value
    logic             ss_d;
    logic             sclk_rise;
    logic             sclk_fall;
    logic             ss_rise;
    logic             ss_fall;
    logic [CNT_W-1:0] rise_cnt;    // Rising edges in this frame
    logic [DW-1:0]    tx_sr;
    logic [DW-1:0]    rx_sr;

    // --------------------------------------------------
    // Input synchronizers and edge detect
    // --------------------------------------------------
    always_ff @(posedge pllClk_i) begin
        if (!rst_n_i) begin
            sclk_sync <= '0;         // SCLK idles low
            ss_sync   <= '1;         // Select idles high
            sclk_d    <= 1'b0;
            ss_d      <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[SYNC-2:0], link.sclk};
            ss_sync   <= {ss_sync[SYNC-2:0], link.ss_n};
            sclk_d    <= sclk_s;
            ss_d      <= ss_s;
        end
    end

    assign sclk_s    = sclk_sync[SYNC-1];
    assign ss_s      = ss_sync[SYNC-1];
    assign sclk_rise = sclk_s & ~sclk_d;
    assign sclk_fall = ~sclk_s & sclk_d;
    assign ss_rise   = ss_s & ~ss_d;
    assign ss_fall   = ~ss_s & ss_d;

    // --------------------------------------------------
    // Frame control
    // --------------------------------------------------
    always_ff @(posedge pllClk_i) begin
        if (!rst_n_i) begin
            state     <= spi_pkg::S_IDLE;
            rise_cnt  <= '0;
            rx_byte_o <= '0;
        end else begin
            case (state)
                spi_pkg::S_IDLE: begin
                    if (ss_fall) begin
                        rise_cnt <= '0;
                        state    <= spi_pkg::S_ACTIVE;
                    end
                end
                spi_pkg::S_ACTIVE: begin
                    if (ss_rise) begin
                        rx_byte_o <= rx_sr;              // Publish on deselect
                        state     <= spi_pkg::S_IDLE;
                    end else if (sclk_rise) begin
                        rise_cnt <= rise_cnt + 1'b1;
                    end
                end
                default: state <= spi_pkg::S_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Shift registers
    // --------------------------------------------------
    // MOSI is still stable here, the master only moves it on falls
    always_ff @(posedge pllClk_i) begin
        if (state == spi_pkg::S_IDLE && ss_fall) begin
            tx_sr <= tx_byte_i;                          // MSB on MISO right away
        end else if (state == spi_pkg::S_ACTIVE && sclk_fall) begin
            tx_sr <= {tx_sr[DW-2:0], 1'b0};
        end
        if (state == spi_pkg::S_ACTIVE && sclk_rise) begin
            rx_sr <= {rx_sr[DW-2:0], link.mosi};
        end
    end

    assign link.miso = tx_sr[DW-1];

    // Whole frame must carry one word, no more and no less
    a_full_word: assert property (@(posedge pllClk_i) disable iff (!rst_n_i)
        (state == spi_pkg::S_ACTIVE && ss_rise) |-> (rise_cnt == CNT_W'(DW)));

endmodule

// ==== design/spi_loop_top.sv ====
module spi_loop_top #(
    parameter int CLK_DIV = spi_pkg::CLK_DIV_DEFAULT
) (
    input  logic                       pllClk_i,
    input  logic                       rst_n_i,

    // Four-phase start of a transfer
    input  logic                       send_req_i,
    output logic                       send_ack_o,

    // Payload in both directions
    input  logic [spi_pkg::DATA_W-1:0] byte_to_slave_i,     // Master sends this
    input  logic [spi_pkg::DATA_W-1:0] byte_to_master_i,    // Slave sends this
    output logic [spi_pkg::DATA_W-1:0] byte_from_slave_o,   // Master received
    output logic [spi_pkg::DATA_W-1:0] byte_from_master_o   // Slave received
);

    // --------------------------------------------------
    // SPI wires between the two ends
    // --------------------------------------------------
    spi_link_if link ();

    spi_master #(
        .CLK_DIV    (CLK_DIV)
    ) u_master (
        .pllClk_i   (pllClk_i),
        .rst_n_i    (rst_n_i),
        .send_req_i (send_req_i),
        .send_ack_o (send_ack_o),
        .tx_byte_i  (byte_to_slave_i),
        .rx_byte_o  (byte_from_slave_o),
        .link       (link.mst)
    );

    // Same clock, inputs resynchronized inside
    spi_slave u_slave (
        .pllClk_i   (pllClk_i),
        .rst_n_i    (rst_n_i),
        .tx_byte_i  (byte_to_master_i),
        .rx_byte_o  (byte_from_master_o),
        .link       (link.slv)
    );

endmodule

// ==== tb/tb_spi_loop.sv ====
module tb_spi_loop;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW             = spi_pkg::DATA_W;
    localparam int CLK_DIV        = spi_pkg::CLK_DIV_DEFAULT;
    localparam int RESET_CYCLES   = 8;
    localparam int XFER_BOUND     = 17 * CLK_DIV + 20;          // Worst case per transfer
    localparam int TIMEOUT_CYCLES = 40 * XFER_BOUND;
    localparam int SETTLE_CYCLES  = spi_pkg::SYNC_STAGES + 2;   // Slave publish delay

    logic          pllClk_i;
    logic          rst_n_i;
    logic          send_req;
    logic          send_ack;
    logic [DW-1:0] byte_to_slave;
    logic [DW-1:0] byte_to_master;
    logic [DW-1:0] byte_from_slave;
    logic [DW-1:0] byte_from_master;
    int            cycle_cnt = 0;

    spi_loop_top #(
        .CLK_DIV            (CLK_DIV)
    ) DUT (
        .pllClk_i           (pllClk_i),
        .rst_n_i            (rst_n_i),
        .send_req_i         (send_req),
        .send_ack_o         (send_ack),
        .byte_to_slave_i    (byte_to_slave),
        .byte_to_master_i   (byte_to_master),
        .byte_from_slave_o  (byte_from_slave),
        .byte_from_master_o (byte_from_master)
    );

    // --------------------------------------------------
    // Clock and watchdog
    // --------------------------------------------------
    initial begin
        pllClk_i = 1'b0;
        forever #10 pllClk_i = ~pllClk_i;   // 20 ns period
    end

    always @(posedge pllClk_i) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Checks failed");
        $fatal(1, "Timeout");
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_value(input string test, input logic [DW-1:0] exp,
                               input logic [DW-1:0] got);
        assert (got === exp)
        else report_failure($sformatf("FAIL %s expected %h got %h", test, exp, got));
    endtask

    task automatic check_bit(input string test, input logic exp, input logic got);
        assert (got === exp)
        else report_failure($sformatf("FAIL %s expected %b got %b", test, exp, got));
    endtask

    // Inputs change 2 ns after the edge where outputs are settled
    task automatic next_cycle();
        @(posedge pllClk_i);
        #2;
    endtask

    // ANSI C LCG constants with 32-bit wraparound
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // One full four-phase exchange with req kept high for hold extra cycles
    task automatic run_transfer(input string test, input logic [DW-1:0] to_slave,
                                input logic [DW-1:0] to_master, input int hold);
        int waited;
        byte_to_slave  = to_slave;
        byte_to_master = to_master;
        send_req       = 1'b1;
        waited         = 0;
        while (send_ack !== 1'b1 && waited < XFER_BOUND) begin
            next_cycle();
            waited++;
        end
        assert (send_ack === 1'b1)
        else report_failure($sformatf("%s: ack did not rise within %0d cycles",
                                      test, XFER_BOUND));
        check_value({test, " byte_from_slave"}, to_master, byte_from_slave);
        repeat (hold) begin
            next_cycle();
            check_bit({test, " ack held"}, 1'b1, send_ack);   // Req still high
        end
        send_req = 1'b0;
        waited   = 0;
        while (send_ack !== 1'b0 && waited < 2) begin
            next_cycle();
            waited++;
        end
        assert (send_ack === 1'b0)
        else report_failure($sformatf("%s: ack still high 2 cycles after req dropped", test));
        repeat (SETTLE_CYCLES) next_cycle();
        check_value({test, " byte_from_master"}, to_slave, byte_from_master);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_state();
        repeat (3) next_cycle();                  // Idle with no request
        check_bit("reset ack", 1'b0, send_ack);
        check_value("reset byte_from_slave", '0, byte_from_slave);
        check_value("reset byte_from_master", '0, byte_from_master);
    endtask

    task automatic test_single_transfer();
        run_transfer("single", 8'hA5, 8'h3C, 0);
    endtask

    task automatic test_handshake_hold();
        run_transfer("handshake", 8'h5A, 8'hC3, 20);
    endtask

    // MSB first shows up as a mirrored byte if reversed
    task automatic test_edge_values();
        run_transfer("edge 00/ff", 8'h00, 8'hFF, 0);
        run_transfer("edge ff/00", 8'hFF, 8'h00, 0);
        run_transfer("edge 80/01", 8'h80, 8'h01, 0);
        run_transfer("edge 01/80", 8'h01, 8'h80, 0);
    endtask

    task automatic test_random_burst(input int count);
        logic [31:0]   seed;
        logic [DW-1:0] to_slave;
        logic [DW-1:0] to_master;
        seed = 32'h94e3;
        for (int i = 0; i < count; i++) begin
            seed      = lcg_next(seed);
            to_slave  = seed[DW+15:16];           // Upper bits spread better
            seed      = lcg_next(seed);
            to_master = seed[DW+15:16];
            run_transfer($sformatf("random %0d", i), to_slave, to_master, 0);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst_n_i        = 1'b0;
        send_req       = 1'b0;
        byte_to_slave  = '0;
        byte_to_master = '0;
        repeat (RESET_CYCLES) @(posedge pllClk_i);
        #2;
        rst_n_i = 1'b1;

        test_reset_state();
        test_single_transfer();
        test_handshake_hold();
        test_edge_values();
        test_random_burst(30);

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== flist.f ====
common/spi_pkg.sv
common/spi_link_if.sv
spi_master/spi_master.sv
spi_slave/spi_slave.sv
design/spi_loop_top.sv
tb/tb_spi_loop.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_spi_loop \
    -f flist.f \
    -o tb_spi_loop
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_spi_loop > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
